/* design/rhBusPkg.sv */
// RH memory bus package
// Types carried on the DMA side memory bus

package rhBusPkg;

   ////////////////////////////////////////////////////////////
   // Bus types
   ////////////////////////////////////////////////////////////

   // Word address on the memory bus
   typedef logic [15:0] busAddrT;

   // One data word written to memory
   typedef logic [15:0] busDataT;

endpackage

/* design/rhCtrlIf.sv */
// RH transfer control interface
// Start request from the register block, live status from the engine

interface rhCtrlIf import rhBusPkg::*, rhRegPkg::*; ();

   // Register block to engine
   logic    start;
   busAddrT startAddr;
   regWordT startCount;
   busDataT fillData;
   logic    nemFault;

   // Engine to register block
   logic    busy;
   busAddrT curAddr;
   regWordT curCount;

   modport regs
   (
      output start, startAddr, startCount, fillData, nemFault,
      input  busy, curAddr, curCount
   );

   modport dma
   (
      input  start, startAddr, startCount, fillData, nemFault,
      output busy, curAddr, curCount
   );

endinterface

/* design/rhDma.sv */
// RH transfer engine
// Writes the fill word to consecutive addresses, one request per word,
// and aborts when the NEM monitor fires

module rhDma
   import rhBusPkg::*, rhRegPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   rhCtrlIf.dma    ctrl,
   input  logic    setNem,
   input  logic    busAck,
   output logic    busReq,
   output busAddrT busAddr,
   output busDataT busData
);

   dmaStateT state;
   logic     busyReg;
   busAddrT  addrReg;
   regWordT  countReg;
   busDataT  fillReg;
   logic     abort;

   // Fault seen directly from the monitor or via the register block
   assign abort = setNem || ctrl.nemFault;

   ////////////////////////////////////////////////////////////
   // Transfer state machine
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state    <= IDLE;
         busyReg  <= 1'b0;
         addrReg  <= '0;
         countReg <= '0;
      end
      else
      begin
         case (state)
            IDLE, DONE:
            begin
               if (busyReg)
                  // Gap cycle between words, monitor re-arms here
                  state <= REQ;
               else if (ctrl.start)
               begin
                  addrReg  <= ctrl.startAddr;
                  countReg <= ctrl.startCount;
                  // Zero count finishes without touching the bus
                  if (ctrl.startCount != '0)
                  begin
                     busyReg <= 1'b1;
                     state   <= REQ;
                  end
                  else
                     state <= DONE;
               end
               else
                  state <= IDLE;
            end
            REQ:
            begin
               if (busAck)
               begin
                  // Word written, step to the next one
                  addrReg  <= addrReg + 16'd1;
                  countReg <= countReg - 16'd1;
                  if (countReg == regWordT'(1))
                  begin
                     busyReg <= 1'b0;
                     state   <= DONE;
                  end
                  else
                     state <= IDLE;
               end
               else if (abort)
               begin
                  // Leave address and count at the faulting word
                  busyReg <= 1'b0;
                  state   <= DONE;
               end
            end
            default:
            begin
               busyReg <= 1'b0;
               state   <= IDLE;
            end
         endcase
      end
   end

   // Fill word held for the whole transfer
   always_ff @(posedge clk)
   begin
      if (ctrl.start)
         fillReg <= ctrl.fillData;
   end

   ////////////////////////////////////////////////////////////
   // Bus and status outputs
   ////////////////////////////////////////////////////////////

   assign busReq  = (state == REQ);
   assign busAddr = addrReg;
   assign busData = fillReg;

   assign ctrl.busy     = busyReg;
   assign ctrl.curAddr  = addrReg;
   assign ctrl.curCount = countReg;

endmodule

/* design/rhNem.sv */
// RH non-existent memory monitor
// Times out a bus request that waits too long for its acknowledge

`include "rh_consts.svh"

module rhNem
(
   input  logic clk,
   input  logic rst,
   input  logic busReq,
   input  logic busAck,
   output logic setNem
);

   // Timeout counter, 4 bits hold the reload value
   logic [3:0] nemCount;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         nemCount <= 4'(`RH_NEM_TIMEOUT);
      else if (busReq && !busAck)
      begin
         // Count down while waiting, stop at zero
         if (nemCount != 4'd0)
            nemCount <= nemCount - 4'd1;
      end
      else
         nemCount <= 4'(`RH_NEM_TIMEOUT);
   end

   // Single pulse per stuck request, counter parks at zero afterwards
   assign setNem = (nemCount == 4'd1);

endmodule

/* design/rhRegPkg.sv */
// RH register file package
// Register word type, register select and engine state

package rhRegPkg;

   // Register value as seen by software
   typedef logic [15:0] regWordT;

   // Register select on the register port
   typedef enum logic [2:0]
   {
      SEL_CS1 = 3'd0,
      SEL_WC  = 3'd1,
      SEL_BA  = 3'd2,
      SEL_DB  = 3'd3,
      SEL_CS2 = 3'd4
   } regSelT;

   // Transfer engine states
   // IDLE also serves as the gap cycle between words
   typedef enum logic [1:0]
   {
      IDLE = 2'd0,
      REQ  = 2'd1,
      DONE = 2'd2
   } dmaStateT;

endpackage

/* design/rhRegs.sv */
// RH register block
// CS1, WC, BA, DB and CS2 with write decode, GO pulse and NEM latch

`include "rh_consts.svh"

module rhRegs
   import rhBusPkg::*, rhRegPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   rhCtrlIf.regs   ctrl,
   input  logic    setNem,
   input  logic    regWr,
   input  regSelT  regSel,
   input  regWordT regWrData,
   output regWordT regRdData
);

   regWordT cs1Reg;
   regWordT wcReg;
   busAddrT baReg;
   busDataT dbReg;
   regWordT cs2Reg;
   logic    nemBit;
   logic    trackDly;
   regWordT cs1Rd;
   regWordT cs2Rd;

   ////////////////////////////////////////////////////////////
   // Transfer control
   ////////////////////////////////////////////////////////////

   // GO only takes effect while the controller is ready
   assign ctrl.start = regWr && (regSel == SEL_CS1) &&
                       regWrData[`RH_CS1_GO] && !ctrl.busy;

   assign ctrl.startAddr  = baReg;
   assign ctrl.startCount = wcReg;
   assign ctrl.fillData   = dbReg;
   assign ctrl.nemFault   = setNem;

   ////////////////////////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cs1Reg   <= '0;
         wcReg    <= '0;
         baReg    <= '0;
         dbReg    <= '0;
         cs2Reg   <= '0;
         nemBit   <= 1'b0;
         trackDly <= 1'b0;
      end
      else
      begin
         // One extra cycle picks up the final address and count
         trackDly <= ctrl.busy;

         if (ctrl.busy || trackDly)
         begin
            baReg <= ctrl.curAddr;
            wcReg <= ctrl.curCount;
         end
         else if (regWr && (regSel == SEL_WC))
            wcReg <= regWrData;
         else if (regWr && (regSel == SEL_BA))
            baReg <= regWrData;

         if (regWr && (regSel == SEL_CS1))
            cs1Reg <= regWrData;
         if (regWr && (regSel == SEL_DB))
            dbReg <= regWrData;
         if (regWr && (regSel == SEL_CS2))
            cs2Reg <= regWrData;

         // NEM latched until cleared, a new fault wins over the clear
         if (setNem)
            nemBit <= 1'b1;
         else if (regWr && (regSel == SEL_CS2) && regWrData[`RH_CS2_CLR])
            nemBit <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      // Status bits override the stored values
      cs1Rd                = cs1Reg;
      cs1Rd[`RH_CS1_GO]    = ctrl.busy;
      cs1Rd[`RH_CS1_RDY]   = !ctrl.busy;
      cs2Rd                = cs2Reg;
      cs2Rd[`RH_CS2_CLR]   = 1'b0;
      cs2Rd[`RH_CS2_NEM]   = nemBit;

      case (regSel)
         SEL_CS1: regRdData = cs1Rd;
         SEL_WC:  regRdData = wcReg;
         SEL_BA:  regRdData = baReg;
         SEL_DB:  regRdData = dbReg;
         SEL_CS2: regRdData = cs2Rd;
         default: regRdData = '0;
      endcase
   end

endmodule

/* design/rhTop.sv */
// RH DMA controller top level
// Register block, transfer engine and NEM monitor on plain ports

module rhTop
   import rhBusPkg::*, rhRegPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    regWr,
   input  regSelT  regSel,
   input  regWordT regWrData,
   output regWordT regRdData,
   output logic    busReq,
   output busAddrT busAddr,
   output busDataT busData,
   input  logic    busAck
);

   // Monitor fault to engine and registers
   logic setNem;

   rhCtrlIf ctrl0 ();

   rhRegs regs0
   (
      .clk       (clk),
      .rst       (rst),
      .ctrl      (ctrl0.regs),
      .setNem    (setNem),
      .regWr     (regWr),
      .regSel    (regSel),
      .regWrData (regWrData),
      .regRdData (regRdData)
   );

   rhDma dma0
   (
      .clk     (clk),
      .rst     (rst),
      .ctrl    (ctrl0.dma),
      .setNem  (setNem),
      .busAck  (busAck),
      .busReq  (busReq),
      .busAddr (busAddr),
      .busData (busData)
   );

   // Watches the outgoing request against the incoming acknowledge
   rhNem nem0
   (
      .clk    (clk),
      .rst    (rst),
      .busReq (busReq),
      .busAck (busAck),
      .setNem (setNem)
   );

endmodule

/* design/rh_consts.svh */
// RH disk controller constants
// NEM timeout reload value and register bit positions

`ifndef RH_CONSTS_SVH
`define RH_CONSTS_SVH

////////////////////////////////////////////////////////////
// Non-existent memory monitor
////////////////////////////////////////////////////////////

// Counter reload, fault after 14 cycles without acknowledge
`define RH_NEM_TIMEOUT 15

////////////////////////////////////////////////////////////
// Control/status register bits
////////////////////////////////////////////////////////////

// CS1 bits
`define RH_CS1_GO  0
`define RH_CS1_RDY 7

// CS2 bits, CLR is write-one
`define RH_CS2_CLR 5
`define RH_CS2_NEM 11

`endif

/* flist.f */
+incdir+design
design/rhBusPkg.sv
design/rhRegPkg.sv
design/rhCtrlIf.sv
design/rhNem.sv
design/rhDma.sv
design/rhRegs.sv
design/rhTop.sv
test/rhMemModel.sv
test/rhTb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the RH DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module rhTb \
   -f flist.f -o rhSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/rhSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# Verdict comes from the log
if grep -q "Test failed" sim.log; then
   exit 1
fi
exit 0

/* test/rhMemModel.sv */
// RH memory model
// Acknowledges writes below a size after a set delay and stores the data

module rhMemModel
   import rhBusPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       memClr,
   input  busAddrT    memSize,
   input  logic [7:0] ackDelay,
   input  logic       busReq,
   input  busAddrT    busAddr,
   input  busDataT    busData,
   output logic       busAck
);
   timeunit 1ns;
   timeprecision 100ps;

   busDataT      memData [256];
   logic [255:0] written;
   // Cycles the current request has waited
   logic [7:0]   waitCnt;

   // Nothing at or above the size ever answers
   assign busAck = busReq && (busAddr < memSize) && (waitCnt >= ackDelay);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         waitCnt <= 8'd0;
         written <= '0;
      end
      else
      begin
         if (busReq && !busAck)
            waitCnt <= (waitCnt == 8'hFF) ? waitCnt : waitCnt + 8'd1;
         else
            waitCnt <= 8'd0;
         if (memClr)
            written <= '0;
         else if (busReq && busAck && (busAddr < 16'd256))
            written[busAddr[7:0]] <= 1'b1;
      end
   end

   // Data store, no reset needed
   always_ff @(posedge clk)
   begin
      if (busReq && busAck && (busAddr < 16'd256))
         memData[busAddr[7:0]] <= busData;
   end

endmodule

/* test/rhTb.sv */
// RH DMA controller testbench
// Table driven transfers against a memory model, with NEM faults

`include "rh_consts.svh"

module rhTb
   import rhBusPkg::*, rhRegPkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   // One transfer with its memory setup
   typedef struct
   {
      busAddrT    startAddr;
      regWordT    count;
      busDataT    fill;
      busAddrT    memSize;
      logic [7:0] ackDelay;
      bit         clearFirst;
   } rowT;

   localparam int NumRows = 6;
   // Worst cycles per word, stuck request plus gap
   localparam int WordCost = 16;

   logic       clk;
   logic       rst;
   logic       regWr;
   regSelT     regSel;
   regWordT    regWrData;
   regWordT    regRdData;
   logic       busReq;
   busAddrT    busAddr;
   busDataT    busData;
   logic       busAck;
   logic       memClr;
   busAddrT    memSize;
   logic [7:0] ackDelay;

   rowT rows [NumRows];
   int  errCount;
   int  cycles;
   int  cycleLimit;
   int  runLen;
   int  lastReqLen;
   bit  nemExp;

   rhTop dut0
   (
      .clk       (clk),
      .rst       (rst),
      .regWr     (regWr),
      .regSel    (regSel),
      .regWrData (regWrData),
      .regRdData (regRdData),
      .busReq    (busReq),
      .busAddr   (busAddr),
      .busData   (busData),
      .busAck    (busAck)
   );

   rhMemModel mem0
   (
      .clk      (clk),
      .rst      (rst),
      .memClr   (memClr),
      .memSize  (memSize),
      .ackDelay (ackDelay),
      .busReq   (busReq),
      .busAddr  (busAddr),
      .busData  (busData),
      .busAck   (busAck)
   );

   ////////////////////////////////////////////////////////////
   // Clock, timeout and request length monitor
   ////////////////////////////////////////////////////////////

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= cycleLimit)
      begin
         $display("Timeout: transfers not finished after %0d cycles", cycles);
         $display("Errors: %0d", errCount + 1);
         $display("Test failed");
         $finish;
      end
   end

   // Length of the last busReq pulse, in cycles
   always @(negedge clk)
   begin
      if (rst)
         runLen = 0;
      else if (busReq)
         runLen = runLen + 1;
      else if (runLen != 0)
      begin
         lastReqLen = runLen;
         runLen = 0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic checkWord(input string name, input regWordT got, input regWordT exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         errCount = errCount + 1;
      end
   endtask

   task automatic checkData(input string name, input busDataT got, input busDataT exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         errCount = errCount + 1;
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         errCount = errCount + 1;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Register port access
   ////////////////////////////////////////////////////////////

   // Two cycles, strobe high for one
   task automatic writeReg(input regSelT sel, input regWordT data);
      @(posedge clk);
      #5;
      regWr     = 1'b1;
      regSel    = sel;
      regWrData = data;
      @(posedge clk);
      #5;
      regWr = 1'b0;
   endtask

   // Read data sampled mid cycle
   task automatic readReg(input regSelT sel, output regWordT data);
      @(posedge clk);
      #5;
      regWr  = 1'b0;
      regSel = sel;
      @(negedge clk);
      data = regRdData;
   endtask

   ////////////////////////////////////////////////////////////
   // One table row
   ////////////////////////////////////////////////////////////

   task automatic runRow(input rowT r);
      regWordT rdVal;
      int      nWritten;
      int      room;
      int      idx;
      int      a;
      bit      faulted;
      busAddrT expBa;
      regWordT expWc;

      // Memory setup and fresh write record
      @(posedge clk);
      #5;
      memSize  = r.memSize;
      ackDelay = r.ackDelay;
      memClr   = 1'b1;
      @(posedge clk);
      #5;
      memClr = 1'b0;

      if (r.clearFirst)
      begin
         writeReg(SEL_CS2, regWordT'(1) << `RH_CS2_CLR);
         nemExp = 1'b0;
      end
      writeReg(SEL_BA, r.startAddr);
      writeReg(SEL_WC, r.count);
      writeReg(SEL_DB, r.fill);
      writeReg(SEL_CS1, regWordT'(1) << `RH_CS1_GO);

      // Done when RDY comes back
      do
         readReg(SEL_CS1, rdVal);
      while (!rdVal[`RH_CS1_RDY]);
      repeat (2) @(posedge clk);

      // Words below the size get written, the first one above faults
      if (r.memSize <= r.startAddr)
         nWritten = 0;
      else
      begin
         room     = int'(r.memSize) - int'(r.startAddr);
         nWritten = (room < int'(r.count)) ? room : int'(r.count);
      end
      faulted = (nWritten < int'(r.count));
      expBa   = r.startAddr + busAddrT'(nWritten);
      expWc   = r.count - regWordT'(nWritten);
      if (faulted)
         nemExp = 1'b1;

      readReg(SEL_BA, rdVal);
      checkWord("BA", rdVal, expBa);
      readReg(SEL_WC, rdVal);
      checkWord("WC", rdVal, expWc);
      readReg(SEL_DB, rdVal);
      checkData("DB", rdVal, r.fill);
      readReg(SEL_CS1, rdVal);
      checkWord("CS1", rdVal, regWordT'(1) << `RH_CS1_RDY);
      readReg(SEL_CS2, rdVal);
      checkWord("CS2", rdVal, regWordT'(nemExp) << `RH_CS2_NEM);
      checkBit("busReq", busReq, 1'b0);

      for (a = 0; a < nWritten; a++)
      begin
         idx = int'(r.startAddr) + a;
         checkBit($sformatf("written[%02h]", idx[7:0]), mem0.written[idx[7:0]], 1'b1);
         checkData($sformatf("mem[%02h]", idx[7:0]), mem0.memData[idx[7:0]], r.fill);
      end

      // Exactly the expected words recorded, nothing past the fault
      checkWord("written count", regWordT'($countones(mem0.written)), regWordT'(nWritten));

      if (faulted)
      begin
         // Stuck request lasts the full monitor window
         checkWord("busReq length", regWordT'(lastReqLen), regWordT'(15));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      regWordT rdVal;
      int      i;

      rst        = 1'b1;
      regWr      = 1'b0;
      regSel     = SEL_CS1;
      regWrData  = '0;
      memClr     = 1'b0;
      memSize    = '0;
      ackDelay   = 8'd0;
      errCount   = 0;
      cycles     = 0;
      runLen     = 0;
      lastReqLen = 0;
      nemExp     = 1'b0;

      // Start, count, fill, memory size, ack delay, clear first
      rows[0] = '{16'h0010, 16'd8,  16'hA5C3, 16'd256,  8'd0,  1'b0};
      rows[1] = '{16'h0040, 16'd5,  16'h3C5A, 16'd256,  8'd10, 1'b0};
      rows[2] = '{16'h0078, 16'd12, 16'h0F1E, 16'h0080, 8'd2,  1'b0};
      rows[3] = '{16'h0020, 16'd6,  16'hC001, 16'd256,  8'd1,  1'b1};
      rows[4] = '{16'h0090, 16'd3,  16'h5AA5, 16'h0090, 8'd0,  1'b0};
      // GO with NEM still latched
      rows[5] = '{16'h0030, 16'd4,  16'h7E7E, 16'd256,  8'd3,  1'b0};

      cycleLimit = 200 + NumRows * 60;
      for (i = 0; i < NumRows; i++)
         cycleLimit = cycleLimit + int'(rows[i].count) * WordCost;

      repeat (2) @(posedge clk);
      #5;
      rst = 1'b0;

      // Reset state
      checkBit("busReq", busReq, 1'b0);
      readReg(SEL_CS1, rdVal);
      checkWord("CS1", rdVal, regWordT'(1) << `RH_CS1_RDY);
      readReg(SEL_CS2, rdVal);
      checkWord("CS2", rdVal, '0);

      for (i = 0; i < NumRows; i++)
         runRow(rows[i]);

      $display("Errors: %0d", errCount);
      if (errCount == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule
